//--- lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// width of data words and byte addresses
// on the rv64 core side
`define LSU_XLEN 64

// depth of the data sram in 64-bit words
// word index taken from the low address bits
`define LSU_SRAM_WORDS 256

// extra cycles the sram holds an access
// before it strobes completion
// must be at least 1
`define LSU_SRAM_WAIT 2

`endif

//--- lsu_op_pkg.sv
`default_nettype none
`include "lsu_defines.svh"

package lsu_op_pkg;

    // memory operations presented by the core
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LBU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LW  = 4'd5,
        LWU = 4'd6,
        LD  = 4'd7,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10,
        SD  = 4'd11
    } mem_op_e;

    // request sequencing states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT,
        DONE
    } ctrl_state_e;

    // one request from the core
    typedef struct packed {
        mem_op_e              op;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
    } lsu_req_t;

    // completion back to the core
    typedef struct packed {
        logic                 done;
        logic                 misalign;
        logic [`LSU_XLEN-1:0] rdata;
    } lsu_resp_t;

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(mem_op_e op);
        case (op)
            LH, LHU, SH: op_size = 2'd1;
            LW, LWU, SW: op_size = 2'd2;
            LD, SD:      op_size = 2'd3;
            default:     op_size = 2'd0;
        endcase
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

endpackage

`default_nettype wire

//--- lsu_mem_pkg.sv
`default_nettype none
`include "lsu_defines.svh"

package lsu_mem_pkg;

    // one access towards the data sram
    // addr is a 64-bit word address without the byte offset
    typedef struct packed {
        logic                 rd_en;
        logic                 wr_en;
        logic [`LSU_XLEN-4:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
        // one bit per byte lane
        logic [7:0]           wmask;
        // log2 bytes in the same coding as the core side
        logic [2:0]           size;
    } sram_cmd_t;

    // completion strobes and read word
    typedef struct packed {
        logic                 rd_valid;
        logic                 wr_ok;
        logic [`LSU_XLEN-1:0] rdata;
    } sram_rsp_t;

endpackage

`default_nettype wire

//--- lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_ctrl
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 req_valid_i,
    input  lsu_req_t             req_i,
    output logic                 busy_o,
    output lsu_req_t             held_req_o,
    input  logic [7:0]           st_mask_i,
    input  logic [2:0]           st_size_i,
    input  logic [`LSU_XLEN-1:0] st_data_i,
    output sram_cmd_t            sram_cmd_o,
    input  sram_rsp_t            sram_rsp_i,
    input  logic [`LSU_XLEN-1:0] ld_data_i,
    output lsu_resp_t            resp_o
);

    ctrl_state_e          state_q;
    lsu_req_t             held_q;
    logic                 misalign_q;
    logic [`LSU_XLEN-1:0] rdata_q;
    logic                 accept;
    logic [2:0]           low_mask;
    logic                 misaligned;
    logic                 is_store;
    logic                 sram_done;

    // pulses while busy are dropped
    assign accept = req_valid_i && (state_q == IDLE);

    // offset bits that must be zero for this size
    assign low_mask   = (3'd1 << op_size(req_i.op)) - 3'd1;
    assign misaligned = |(req_i.addr[2:0] & low_mask);

    assign is_store  = op_is_store(held_q.op);
    assign sram_done = sram_rsp_i.rd_valid || sram_rsp_i.wr_ok;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= IDLE;
            misalign_q <= 1'b0;
            rdata_q    <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        rdata_q    <= '0;
                        misalign_q <= misaligned;
                        // refused or empty requests skip the sram
                        if (misaligned || (req_i.op == NOP)) begin
                            state_q <= DONE;
                        end else begin
                            state_q <= ACCESS;
                        end
                    end
                end
                ACCESS: begin
                    state_q <= WAIT;
                end
                WAIT: begin
                    if (sram_done) begin
                        // extended load result
                        // stores keep zero
                        if (!is_store) begin
                            rdata_q <= ld_data_i;
                        end
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            held_q <= req_i;
        end
    end

    assign held_req_o = held_q;
    assign busy_o     = (state_q != IDLE);

    // single-cycle enable while in ACCESS
    always_comb begin
        sram_cmd_o.rd_en = (state_q == ACCESS) && !is_store;
        sram_cmd_o.wr_en = (state_q == ACCESS) && is_store;
        sram_cmd_o.addr  = held_q.addr[`LSU_XLEN-1:3];
        sram_cmd_o.wdata = st_data_i;
        sram_cmd_o.wmask = st_mask_i;
        sram_cmd_o.size  = st_size_i;
    end

    always_comb begin
        resp_o.done     = (state_q == DONE);
        resp_o.misalign = misalign_q;
        resp_o.rdata    = rdata_q;
    end

endmodule

`default_nettype wire

//--- lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_load_align
    import lsu_op_pkg::*;
(
    input  lsu_req_t             req_i,
    input  logic [`LSU_XLEN-1:0] word_i,
    output logic [`LSU_XLEN-1:0] data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] word_sel;

    // byte lane by offset 2:0
    assign byte_sel = word_i[{req_i.addr[2:0], 3'b000} +: 8];

    // halfword lane by offset 2:1
    assign half_sel = word_i[{req_i.addr[2:1], 4'b0000} +: 16];

    // word lane by offset bit 2
    assign word_sel = word_i[{req_i.addr[2], 5'b00000} +: 32];

    // extension by opcode
    always_comb begin
        case (req_i.op)
            LB:      data_o = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
            LBU:     data_o = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
            LH:      data_o = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
            LHU:     data_o = {{(`LSU_XLEN-16){1'b0}}, half_sel};
            LW:      data_o = {{(`LSU_XLEN-32){word_sel[31]}}, word_sel};
            LWU:     data_o = {{(`LSU_XLEN-32){1'b0}}, word_sel};
            // full doubleword as read
            LD:      data_o = word_i;
            // stores and nop
            default: data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- lsu_store_format.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_store_format
    import lsu_op_pkg::*;
(
    input  lsu_req_t             req_i,
    output logic [7:0]           mask_o,
    output logic [2:0]           size_o,
    output logic [`LSU_XLEN-1:0] data_o
);

    logic [7:0] base_mask;
    logic       is_store;

    assign is_store = op_is_store(req_i.op);

    // lanes touched at offset zero
    always_comb begin
        case (req_i.op)
            SB:      base_mask = 8'b0000_0001;
            SH:      base_mask = 8'b0000_0011;
            SW:      base_mask = 8'b0000_1111;
            SD:      base_mask = 8'b1111_1111;
            // loads write nothing
            default: base_mask = 8'b0000_0000;
        endcase
    end

    // loads still report their own size
    assign size_o = {1'b0, op_size(req_i.op)};

    // move mask and data up to the addressed lane
    assign mask_o = base_mask << req_i.addr[2:0];
    assign data_o = is_store ? (req_i.wdata << {req_i.addr[2:0], 3'b000}) : '0;

endmodule

`default_nettype wire

//--- lsu_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_sram
    import lsu_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  sram_cmd_t cmd_i,
    output sram_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);
    localparam int CNT_W = $clog2(`LSU_SRAM_WAIT + 1);

    logic [`LSU_XLEN-1:0] mem [`LSU_SRAM_WORDS];
    sram_cmd_t            pend_q;
    logic                 active_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 rd_valid_q;
    logic                 wr_ok_q;
    logic [`LSU_XLEN-1:0] rdata_q;
    logic                 start;
    logic                 fire;
    logic [IDX_W-1:0]     idx;

    // one access at a time
    assign start = !active_q && (cmd_i.rd_en || cmd_i.wr_en);
    assign fire  = active_q && (cnt_q == '0);

    // upper word address bits wrap
    assign idx = pend_q.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active_q   <= 1'b0;
            cnt_q      <= '0;
            rd_valid_q <= 1'b0;
            wr_ok_q    <= 1'b0;
        end else begin
            // strobes last one cycle
            rd_valid_q <= 1'b0;
            wr_ok_q    <= 1'b0;
            if (start) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(`LSU_SRAM_WAIT - 1);
            end else if (fire) begin
                active_q   <= 1'b0;
                rd_valid_q <= pend_q.rd_en;
                wr_ok_q    <= pend_q.wr_en;
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // command held for the whole wait
    always_ff @(posedge clk) begin
        if (start) begin
            pend_q <= cmd_i;
        end
    end

    // array updated on the completion edge
    always_ff @(posedge clk) begin
        if (fire && pend_q.wr_en) begin
            for (int b = 0; b < 8; b++) begin
                if (pend_q.wmask[b]) begin
                    mem[idx][8*b +: 8] <= pend_q.wdata[8*b +: 8];
                end
            end
        end
        // read word held until the next read
        if (fire && pend_q.rd_en) begin
            rdata_q <= mem[idx];
        end
    end

    always_comb begin
        rsp_o.rd_valid = rd_valid_q;
        rsp_o.wr_ok    = wr_ok_q;
        rsp_o.rdata    = rdata_q;
    end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_top
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  lsu_req_t  req_i,
    output logic      busy_o,
    output lsu_resp_t resp_o
);

    // accepted request to both datapath halves
    lsu_req_t             held_req;
    // formatted store towards the controller
    logic [7:0]           st_mask;
    logic [2:0]           st_size;
    logic [`LSU_XLEN-1:0] st_data;
    // extended load result
    logic [`LSU_XLEN-1:0] ld_data;
    sram_cmd_t            sram_cmd;
    sram_rsp_t            sram_rsp;

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .held_req_o  (held_req),
        .st_mask_i   (st_mask),
        .st_size_i   (st_size),
        .st_data_i   (st_data),
        .sram_cmd_o  (sram_cmd),
        .sram_rsp_i  (sram_rsp),
        .ld_data_i   (ld_data),
        .resp_o      (resp_o)
    );

    lsu_load_align u_load_align (
        .req_i  (held_req),
        .word_i (sram_rsp.rdata),
        .data_o (ld_data)
    );

    lsu_store_format u_store_format (
        .req_i  (held_req),
        .mask_o (st_mask),
        .size_o (st_size),
        .data_o (st_data)
    );

    lsu_sram u_sram (
        .clk   (clk),
        .rst_i (rst_i),
        .cmd_i (sram_cmd),
        .rsp_o (sram_rsp)
    );

endmodule

`default_nettype wire

//--- tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module tb_lsu
    import lsu_op_pkg::*;
();

    localparam logic [31:0] SEED = 32'h3c247beb;
    localparam int MODEL_BYTES = `LSU_SRAM_WORDS * 8;
    localparam int IDX_BITS = $clog2(MODEL_BYTES);
    localparam int REQ_CYCLES = 4 + `LSU_SRAM_WAIT;
    // 8 + 29 + 58 + 8 + 5 requests over the tests below
    localparam int N_REQ = 108;
    localparam int WATCHDOG_CYCLES = N_REQ * REQ_CYCLES + 50;

    logic        clk;
    logic        rst_i;
    logic        req_valid_i;
    lsu_req_t    req_i;
    logic        busy_o;
    lsu_resp_t   resp_o;

    // byte-wide reference memory
    logic [7:0]  model [MODEL_BYTES];
    logic [31:0] rng_state;
    int          checks;
    int          fails;

    lsu_top dut0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .resp_o      (resp_o)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        rng_state = xorshift32(rng_state);
        hi = rng_state;
        rng_state = xorshift32(rng_state);
        return {hi, rng_state};
    endfunction

    // bytes moved by each opcode
    function automatic int access_bytes(mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic void model_write(mem_op_e op, logic [63:0] addr, logic [63:0] data);
        for (int i = 0; i < access_bytes(op); i++) begin
            model[int'(addr[IDX_BITS-1:0]) + i] = data[8*i +: 8];
        end
    endfunction

    // little-endian gather then sign or zero extension
    function automatic logic [63:0] expected_load(mem_op_e op, logic [63:0] addr);
        int          n;
        logic [63:0] val;
        n = access_bytes(op);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = model[int'(addr[IDX_BITS-1:0]) + i];
        end
        if ((op == LB || op == LH || op == LW) && val[8*n-1]) begin
            val = val | (64'hFFFF_FFFF_FFFF_FFFF << (8 * n));
        end
        return val;
    endfunction

    function automatic lsu_req_t make_req(mem_op_e op, logic [63:0] addr, logic [63:0] data);
        lsu_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fails++;
        end
    endtask

    task automatic report(string name, int checks0, int fails0);
        $display("%s finished, %0d checks, %0d mismatches", name, checks - checks0,
                 fails - fails0);
    endtask

    task automatic wait_done(output lsu_resp_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!resp_o.done && n < REQ_CYCLES + 4) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (resp_o.done) else begin
            $display("no done pulse within %0d cycles of the request", REQ_CYCLES + 4);
            fails++;
        end
        r = resp_o;
    endtask

    // single request pulse
    // busy must already be low before the accept edge
    task automatic issue(mem_op_e op, logic [63:0] addr, logic [63:0] data,
                         output lsu_resp_t r);
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= make_req(op, addr, data);
        @(negedge clk);
        check_value("busy_o", 64'(busy_o), 64'd0);
        @(posedge clk);
        req_valid_i <= 1'b0;
        wait_done(r);
    endtask

    task automatic do_store(mem_op_e op, logic [63:0] addr, logic [63:0] data);
        lsu_resp_t r;
        issue(op, addr, data, r);
        check_value("resp_o.misalign", 64'(r.misalign), 64'd0);
        model_write(op, addr, data);
    endtask

    task automatic do_load(mem_op_e op, logic [63:0] addr);
        lsu_resp_t r;
        issue(op, addr, 64'd0, r);
        check_value("resp_o.misalign", 64'(r.misalign), 64'd0);
        check_value("resp_o.rdata", r.rdata, expected_load(op, addr));
    endtask

    // refused request leaves memory and model untouched
    task automatic do_refused(mem_op_e op, logic [63:0] addr);
        lsu_resp_t r;
        issue(op, addr, rand64(), r);
        check_value("resp_o.misalign", 64'(r.misalign), 64'd1);
    endtask

    task automatic sweep_loads(mem_op_e s_op, mem_op_e u_op, logic [63:0] base, int step);
        for (int off = 0; off < 8; off += step) begin
            do_load(s_op, base + 64'(off));
            do_load(u_op, base + 64'(off));
        end
    endtask

    task automatic test_reset_state();
        int c0;
        int f0;
        c0 = checks;
        f0 = fails;
        repeat (3) begin
            @(negedge clk);
            check_value("busy_o", 64'(busy_o), 64'd0);
            check_value("resp_o.done", 64'(resp_o.done), 64'd0);
            check_value("resp_o.misalign", 64'(resp_o.misalign), 64'd0);
            check_value("resp_o.rdata", resp_o.rdata, 64'd0);
        end
        report("reset state", c0, f0);
    endtask

    task automatic test_dword_round_trip();
        logic [63:0] addrs [4];
        int          c0;
        int          f0;
        c0 = checks;
        f0 = fails;
        addrs[0] = 64'h000;
        addrs[1] = 64'h008;
        addrs[2] = 64'h3f8;
        // last word of the array
        addrs[3] = 64'h7f8;
        for (int i = 0; i < 4; i++) begin
            do_store(SD, addrs[i], rand64());
        end
        for (int i = 0; i < 4; i++) begin
            do_load(LD, addrs[i]);
        end
        report("doubleword round trip", c0, f0);
    endtask

    task automatic test_lane_masking();
        int c0;
        int f0;
        c0 = checks;
        f0 = fails;
        do_store(SD, 64'h100, rand64());
        for (int off = 0; off < 8; off++) begin
            do_store(SB, 64'h100 + 64'(off), rand64());
            do_load(LD, 64'h100);
        end
        for (int off = 0; off < 8; off += 2) begin
            do_store(SH, 64'h100 + 64'(off), rand64());
            do_load(LD, 64'h100);
        end
        for (int off = 0; off < 8; off += 4) begin
            do_store(SW, 64'h100 + 64'(off), rand64());
            do_load(LD, 64'h100);
        end
        report("partial stores and lane masking", c0, f0);
    endtask

    task automatic test_load_extension();
        int c0;
        int f0;
        c0 = checks;
        f0 = fails;
        // every byte with its top bit set
        do_store(SD, 64'h200, 64'hF1E2_D3C4_B5A6_9788);
        // every byte with its top bit clear
        do_store(SD, 64'h208, 64'h0F1E_2D3C_4B5A_6978);
        for (int p = 0; p < 2; p++) begin
            sweep_loads(LB, LBU, 64'h200 + 64'(8 * p), 1);
            sweep_loads(LH, LHU, 64'h200 + 64'(8 * p), 2);
            sweep_loads(LW, LWU, 64'h200 + 64'(8 * p), 4);
        end
        report("load extension", c0, f0);
    endtask

    task automatic test_misaligned();
        int c0;
        int f0;
        c0 = checks;
        f0 = fails;
        do_store(SD, 64'h300, rand64());
        do_refused(LH, 64'h301);
        do_refused(SH, 64'h301);
        do_refused(LW, 64'h302);
        do_refused(SW, 64'h302);
        do_refused(LD, 64'h304);
        do_refused(SD, 64'h304);
        do_load(LD, 64'h300);
        report("misaligned refusal", c0, f0);
    endtask

    task automatic test_busy_ignore();
        logic [63:0] a_data;
        logic [63:0] b_data;
        int          dones;
        int          c0;
        int          f0;
        c0 = checks;
        f0 = fails;
        do_store(SD, 64'h408, rand64());
        a_data = rand64();
        b_data = rand64();
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= make_req(SD, 64'h400, a_data);
        @(posedge clk);
        // first request taken on this edge
        // second pulse meets busy high
        req_i <= make_req(SD, 64'h408, b_data);
        @(negedge clk);
        check_value("busy_o", 64'(busy_o), 64'd1);
        @(posedge clk);
        req_valid_i <= 1'b0;
        dones = 0;
        repeat (REQ_CYCLES + 2) begin
            @(negedge clk);
            if (resp_o.done) begin
                dones++;
            end
        end
        check_value("resp_o.done pulses", 64'(dones), 64'd1);
        model_write(SD, 64'h400, a_data);
        do_load(LD, 64'h408);
        do_load(LD, 64'h400);
        report("busy ignore", c0, f0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rng_state   = SEED;
        checks      = 0;
        fails       = 0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        test_reset_state();
        test_dword_round_trip();
        test_lane_masking();
        test_load_extension();
        test_misaligned();
        test_busy_ignore();
        $display("checks %0d, passed %0d, mismatched %0d", checks, checks - fails, fails);
        if (fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
lsu_op_pkg.sv
lsu_mem_pkg.sv
lsu_ctrl.sv
lsu_load_align.sv
lsu_store_format.sv
lsu_sram.sv
lsu_top.sv
tb_lsu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_lsu
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
